// ==== src/cpu_cfg.svh ====
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// datapath and instruction tag widths
`define CPU_XLEN 32
`define CPU_TAG_WIDTH 8
`define CPU_REG_INDEX_WIDTH 5

// the divider retires CPU_DIV_BITS_PER_STAGE quotient bits in each of its stages,
// so the product of these two must equal CPU_XLEN
`define CPU_DIV_STAGES 8
`define CPU_DIV_BITS_PER_STAGE 4

`endif

// ==== src/cpu_types_pkg.sv ====
`include "cpu_cfg.svh"

package cpu_types_pkg;

	typedef logic [`CPU_XLEN-1:0] word_t;
	typedef logic [2*`CPU_XLEN-1:0] dword_t;
	typedef logic [`CPU_TAG_WIDTH-1:0] tag_t;
	typedef logic [`CPU_REG_INDEX_WIDTH-1:0] reg_index_t;

	// access size in bytes, 0 when no access is made
	typedef logic [2:0] mem_width_t;

	typedef enum logic [1:0] {
		IDLE,
		MUL_WAIT,
		DIV_WAIT
	} exec_state_t;

endpackage

// ==== src/rv_isa_pkg.sv ====
package rv_isa_pkg;

	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111,
		BRANCH = 7'b1100011,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011
	} opcode_t;

	typedef enum logic [2:0] {
		BEQ  = 3'b000,
		BNE  = 3'b001,
		BLT  = 3'b100,
		BGE  = 3'b101,
		BLTU = 3'b110,
		BGEU = 3'b111
	} branch_funct3_t;

	// stores share the byte, half and word encodings with loads
	typedef enum logic [2:0] {
		MEM_B  = 3'b000,
		MEM_H  = 3'b001,
		MEM_W  = 3'b010,
		MEM_BU = 3'b100,
		MEM_HU = 3'b101
	} mem_funct3_t;

	typedef enum logic [2:0] {
		MUL    = 3'b000,
		MULH   = 3'b001,
		MULHSU = 3'b010,
		MULHU  = 3'b011,
		DIV    = 3'b100,
		DIVU   = 3'b101,
		REM    = 3'b110,
		REMU   = 3'b111
	} m_funct3_t;

	typedef enum logic [6:0] {
		F7_ALT    = 7'b0100000,
		F7_MULDIV = 7'b0000001
	} funct7_t;

	// the low three bits follow funct3 of the OP group, so most ops decode directly
	typedef enum logic [3:0] {
		ADD  = 4'd0,
		SLL  = 4'd1,
		SLT  = 4'd2,
		SLTU = 4'd3,
		XOR  = 4'd4,
		SRL  = 4'd5,
		OR   = 4'd6,
		AND  = 4'd7,
		SUB  = 4'd8,
		EQ   = 4'd9,
		NE   = 4'd10,
		GE   = 4'd11,
		GEU  = 4'd12,
		SRA  = 4'd13
	} alu_op_t;

endpackage

// ==== src/cpu_alu.sv ====
`timescale 1ns/100ps

module cpu_alu (
	input rv_isa_pkg::alu_op_t i_op,
	input cpu_types_pkg::word_t i_op1,
	input cpu_types_pkg::word_t i_op2,
	output cpu_types_pkg::word_t o_result
);

	logic [4:0] shift_amount;
	logic less_signed;
	logic less_unsigned;

	assign shift_amount = i_op2[4:0];
	assign less_signed = $signed(i_op1) < $signed(i_op2);
	assign less_unsigned = i_op1 < i_op2;

	always_comb begin
		case (i_op)
			rv_isa_pkg::ADD: o_result = i_op1 + i_op2;
			rv_isa_pkg::SUB: o_result = i_op1 - i_op2;
			rv_isa_pkg::SLL: o_result = i_op1 << shift_amount;
			rv_isa_pkg::SRL: o_result = i_op1 >> shift_amount;
			rv_isa_pkg::SRA: o_result = $signed(i_op1) >>> shift_amount;
			rv_isa_pkg::XOR: o_result = i_op1 ^ i_op2;
			rv_isa_pkg::OR: o_result = i_op1 | i_op2;
			rv_isa_pkg::AND: o_result = i_op1 & i_op2;
			// compares and branch conditions give a single bit
			rv_isa_pkg::SLT: o_result = cpu_types_pkg::word_t'(less_signed);
			rv_isa_pkg::SLTU: o_result = cpu_types_pkg::word_t'(less_unsigned);
			rv_isa_pkg::GE: o_result = cpu_types_pkg::word_t'(!less_signed);
			rv_isa_pkg::GEU: o_result = cpu_types_pkg::word_t'(!less_unsigned);
			rv_isa_pkg::EQ: o_result = cpu_types_pkg::word_t'(i_op1 == i_op2);
			rv_isa_pkg::NE: o_result = cpu_types_pkg::word_t'(i_op1 != i_op2);
			default: o_result = '0;
		endcase
	end

endmodule

// ==== src/cpu_multiply.sv ====
`timescale 1ns/100ps
`include "cpu_cfg.svh"

module cpu_multiply (
	input logic i_clock,
	input cpu_types_pkg::word_t i_op1,
	input cpu_types_pkg::word_t i_op2,
	input logic i_op1_signed,
	input logic i_op2_signed,
	input logic i_high,
	output cpu_types_pkg::word_t o_result
);

	// one extra bit per operand lets a single signed multiply cover all four variants
	logic signed [`CPU_XLEN:0] op1_ext;
	logic signed [`CPU_XLEN:0] op2_ext;
	logic signed [2*`CPU_XLEN+1:0] product_ext;
	cpu_types_pkg::dword_t product;

	assign op1_ext = {i_op1_signed & i_op1[`CPU_XLEN-1], i_op1};
	assign op2_ext = {i_op2_signed & i_op2[`CPU_XLEN-1], i_op2};
	assign product_ext = op1_ext * op2_ext;
	assign product = product_ext[2*`CPU_XLEN-1:0];

	always_ff @(posedge i_clock) begin
		o_result <= i_high ? product[2*`CPU_XLEN-1:`CPU_XLEN] : product[`CPU_XLEN-1:0];
	end

endmodule

// ==== src/cpu_divide_prepare.sv ====
`timescale 1ns/100ps
`include "cpu_cfg.svh"

module cpu_divide_prepare (
	input logic i_clock,
	input logic i_reset,
	input logic i_start,
	input cpu_types_pkg::word_t i_dividend,
	input cpu_types_pkg::word_t i_divisor,
	input logic i_signed,
	input logic i_remainder,
	output logic o_valid,
	output cpu_types_pkg::word_t o_dividend_mag,
	output cpu_types_pkg::word_t o_divisor_mag,
	output logic o_quotient_negative,
	output logic o_remainder_negative,
	output logic o_by_zero,
	output logic o_overflow,
	output logic o_remainder_sel,
	output cpu_types_pkg::word_t o_raw_dividend
);

	logic dividend_negative;
	logic divisor_negative;
	logic most_negative;

	assign dividend_negative = i_signed & i_dividend[`CPU_XLEN-1];
	assign divisor_negative = i_signed & i_divisor[`CPU_XLEN-1];
	assign most_negative = i_dividend == {1'b1, {(`CPU_XLEN-1){1'b0}}};

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_valid <= 1'b0;
		end else begin
			o_valid <= i_start;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_start) begin
			o_dividend_mag <= dividend_negative ? -i_dividend : i_dividend;
			o_divisor_mag <= divisor_negative ? -i_divisor : i_divisor;
			// the remainder takes the sign of the dividend
			o_quotient_negative <= dividend_negative ^ divisor_negative;
			o_remainder_negative <= dividend_negative;
			o_by_zero <= i_divisor == '0;
			o_overflow <= i_signed && most_negative && i_divisor == '1;
			o_remainder_sel <= i_remainder;
			o_raw_dividend <= i_dividend;
		end
	end

endmodule

// ==== src/cpu_divide_stage.sv ====
`timescale 1ns/100ps
`include "cpu_cfg.svh"

module cpu_divide_stage (
	input logic i_clock,
	input logic i_reset,
	input logic i_valid,
	input cpu_types_pkg::word_t i_quotient,
	input cpu_types_pkg::word_t i_partial_remainder,
	input cpu_types_pkg::word_t i_dividend_rest,
	input cpu_types_pkg::word_t i_divisor,
	input logic i_quotient_negative,
	input logic i_remainder_negative,
	input logic i_by_zero,
	input logic i_overflow,
	input logic i_remainder_sel,
	input cpu_types_pkg::word_t i_raw_dividend,
	output logic o_valid,
	output cpu_types_pkg::word_t o_quotient,
	output cpu_types_pkg::word_t o_partial_remainder,
	output cpu_types_pkg::word_t o_dividend_rest,
	output cpu_types_pkg::word_t o_divisor,
	output logic o_quotient_negative,
	output logic o_remainder_negative,
	output logic o_by_zero,
	output logic o_overflow,
	output logic o_remainder_sel,
	output cpu_types_pkg::word_t o_raw_dividend
);

	cpu_types_pkg::word_t quotient;
	cpu_types_pkg::word_t remainder;
	cpu_types_pkg::word_t rest;
	logic [`CPU_XLEN:0] trial;

	// the remainder stays below the divisor, so one guard bit is enough for the trial
	always_comb begin
		quotient = i_quotient;
		remainder = i_partial_remainder;
		rest = i_dividend_rest;
		trial = '0;
		for (int step = 0; step < `CPU_DIV_BITS_PER_STAGE; step++) begin
			trial = {remainder, rest[`CPU_XLEN-1]} - {1'b0, i_divisor};
			if (!trial[`CPU_XLEN]) begin
				remainder = trial[`CPU_XLEN-1:0];
				quotient = {quotient[`CPU_XLEN-2:0], 1'b1};
			end else begin
				remainder = {remainder[`CPU_XLEN-2:0], rest[`CPU_XLEN-1]};
				quotient = {quotient[`CPU_XLEN-2:0], 1'b0};
			end
			rest = rest << 1;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_valid <= 1'b0;
		end else begin
			o_valid <= i_valid;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_valid) begin
			o_quotient <= quotient;
			o_partial_remainder <= remainder;
			o_dividend_rest <= rest;
			o_divisor <= i_divisor;
			o_quotient_negative <= i_quotient_negative;
			o_remainder_negative <= i_remainder_negative;
			o_by_zero <= i_by_zero;
			o_overflow <= i_overflow;
			o_remainder_sel <= i_remainder_sel;
			o_raw_dividend <= i_raw_dividend;
		end
	end

endmodule

// ==== src/cpu_divide_finish.sv ====
`timescale 1ns/100ps

module cpu_divide_finish (
	input logic i_clock,
	input logic i_reset,
	input logic i_valid,
	input cpu_types_pkg::word_t i_quotient,
	input cpu_types_pkg::word_t i_remainder,
	input logic i_quotient_negative,
	input logic i_remainder_negative,
	input logic i_by_zero,
	input logic i_overflow,
	input logic i_remainder_sel,
	input cpu_types_pkg::word_t i_raw_dividend,
	output logic o_done,
	output cpu_types_pkg::word_t o_result
);

	cpu_types_pkg::word_t quotient;
	cpu_types_pkg::word_t remainder;

	always_comb begin
		quotient = i_quotient_negative ? -i_quotient : i_quotient;
		remainder = i_remainder_negative ? -i_remainder : i_remainder;
		// RISC-V defines these results instead of trapping
		if (i_by_zero) begin
			quotient = '1;
			remainder = i_raw_dividend;
		end else if (i_overflow) begin
			quotient = i_raw_dividend;
			remainder = '0;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_done <= 1'b0;
		end else begin
			o_done <= i_valid;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_valid) begin
			o_result <= i_remainder_sel ? remainder : quotient;
		end
	end

endmodule

// ==== src/cpu_execute.sv ====
`timescale 1ns/100ps
`include "cpu_cfg.svh"

module cpu_execute (
	input logic i_clock,
	input logic i_reset,
	input logic i_stall,
	input cpu_types_pkg::tag_t i_tag,
	input cpu_types_pkg::word_t i_pc,
	input cpu_types_pkg::word_t i_instruction,
	input cpu_types_pkg::word_t i_rs1,
	input cpu_types_pkg::word_t i_rs2,
	input cpu_types_pkg::word_t i_imm,
	input cpu_types_pkg::reg_index_t i_inst_rd,
	output cpu_types_pkg::tag_t o_tag,
	output cpu_types_pkg::reg_index_t o_inst_rd,
	output cpu_types_pkg::word_t o_rd,
	output cpu_types_pkg::word_t o_pc_next,
	output cpu_types_pkg::word_t o_mem_address,
	output logic o_mem_read,
	output logic o_mem_write,
	output logic o_mem_signed,
	output cpu_types_pkg::mem_width_t o_mem_width,
	output logic o_stall
);

	cpu_types_pkg::exec_state_t state;
	logic mul_primed;

	rv_isa_pkg::opcode_t opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic alt_op;
	rv_isa_pkg::branch_funct3_t branch_funct;
	rv_isa_pkg::mem_funct3_t mem_funct;
	rv_isa_pkg::m_funct3_t m_funct;

	rv_isa_pkg::alu_op_t alu_op;
	cpu_types_pkg::word_t alu_op1;
	cpu_types_pkg::word_t alu_op2;
	cpu_types_pkg::word_t alu_result;
	cpu_types_pkg::word_t pc_plus4;
	cpu_types_pkg::word_t pc_imm;
	cpu_types_pkg::mem_width_t mem_width;
	logic mem_signed;

	logic is_muldiv;
	logic is_mul;
	logic is_div;
	logic accept;
	cpu_types_pkg::word_t mul_result;

	logic div_done;
	cpu_types_pkg::word_t div_result;
	logic [`CPU_DIV_STAGES:0] stage_valid;
	cpu_types_pkg::word_t stage_quotient [0:`CPU_DIV_STAGES];
	cpu_types_pkg::word_t stage_remainder [0:`CPU_DIV_STAGES];
	cpu_types_pkg::word_t stage_rest [0:`CPU_DIV_STAGES];
	cpu_types_pkg::word_t stage_divisor [0:`CPU_DIV_STAGES];
	cpu_types_pkg::word_t stage_raw_dividend [0:`CPU_DIV_STAGES];
	logic [`CPU_DIV_STAGES:0] stage_quotient_negative;
	logic [`CPU_DIV_STAGES:0] stage_remainder_negative;
	logic [`CPU_DIV_STAGES:0] stage_by_zero;
	logic [`CPU_DIV_STAGES:0] stage_overflow;
	logic [`CPU_DIV_STAGES:0] stage_remainder_sel;

	assign opcode = rv_isa_pkg::opcode_t'(i_instruction[6:0]);
	assign funct3 = i_instruction[14:12];
	assign funct7 = i_instruction[31:25];
	assign alt_op = funct7 == rv_isa_pkg::F7_ALT;
	assign branch_funct = rv_isa_pkg::branch_funct3_t'(funct3);
	assign mem_funct = rv_isa_pkg::mem_funct3_t'(funct3);
	assign m_funct = rv_isa_pkg::m_funct3_t'(funct3);

	assign pc_plus4 = i_pc + 4;
	assign pc_imm = i_pc + i_imm;

	assign is_muldiv = opcode == rv_isa_pkg::OP && funct7 == rv_isa_pkg::F7_MULDIV;
	assign is_mul = is_muldiv && m_funct inside {rv_isa_pkg::MUL, rv_isa_pkg::MULH,
		rv_isa_pkg::MULHSU, rv_isa_pkg::MULHU};
	assign is_div = is_muldiv && m_funct inside {rv_isa_pkg::DIV, rv_isa_pkg::DIVU,
		rv_isa_pkg::REM, rv_isa_pkg::REMU};

	assign accept = !i_stall && i_tag != o_tag && state == cpu_types_pkg::IDLE;
	assign o_stall = state != cpu_types_pkg::IDLE;

	// loads, stores and JALR share the default rs1 + imm
	always_comb begin
		alu_op = rv_isa_pkg::ADD;
		alu_op1 = i_rs1;
		alu_op2 = i_imm;
		case (opcode)
			rv_isa_pkg::OP: begin
				alu_op = rv_isa_pkg::alu_op_t'({alt_op && (funct3 == 3'b000 || funct3 == 3'b101),
					funct3});
				alu_op2 = i_rs2;
			end
			rv_isa_pkg::OP_IMM: begin
				// bit 30 of an immediate only selects SRAI
				alu_op = rv_isa_pkg::alu_op_t'({alt_op && funct3 == 3'b101, funct3});
			end
			rv_isa_pkg::AUIPC: begin
				alu_op1 = i_pc;
			end
			rv_isa_pkg::BRANCH: begin
				alu_op2 = i_rs2;
				case (branch_funct)
					rv_isa_pkg::BEQ: alu_op = rv_isa_pkg::EQ;
					rv_isa_pkg::BNE: alu_op = rv_isa_pkg::NE;
					rv_isa_pkg::BLT: alu_op = rv_isa_pkg::SLT;
					rv_isa_pkg::BGE: alu_op = rv_isa_pkg::GE;
					rv_isa_pkg::BLTU: alu_op = rv_isa_pkg::SLTU;
					rv_isa_pkg::BGEU: alu_op = rv_isa_pkg::GEU;
					default: alu_op = rv_isa_pkg::EQ;
				endcase
			end
			default: begin
			end
		endcase
	end

	always_comb begin
		mem_width = 3'd0;
		mem_signed = 1'b0;
		case (mem_funct)
			rv_isa_pkg::MEM_B: begin
				mem_width = 3'd1;
				mem_signed = 1'b1;
			end
			rv_isa_pkg::MEM_H: begin
				mem_width = 3'd2;
				mem_signed = 1'b1;
			end
			rv_isa_pkg::MEM_W: mem_width = 3'd4;
			rv_isa_pkg::MEM_BU: mem_width = 3'd1;
			rv_isa_pkg::MEM_HU: mem_width = 3'd2;
			default: mem_width = 3'd0;
		endcase
	end

	cpu_alu i_cpu_alu (
		.i_op(alu_op),
		.i_op1(alu_op1),
		.i_op2(alu_op2),
		.o_result(alu_result)
	);

	cpu_multiply i_cpu_multiply (
		.i_clock(i_clock),
		.i_op1(i_rs1),
		.i_op2(i_rs2),
		.i_op1_signed(m_funct == rv_isa_pkg::MULH || m_funct == rv_isa_pkg::MULHSU),
		.i_op2_signed(m_funct == rv_isa_pkg::MULH),
		.i_high(m_funct != rv_isa_pkg::MUL),
		.o_result(mul_result)
	);

	cpu_divide_prepare i_cpu_divide_prepare (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_start(accept && is_div),
		.i_dividend(i_rs1),
		.i_divisor(i_rs2),
		.i_signed(m_funct == rv_isa_pkg::DIV || m_funct == rv_isa_pkg::REM),
		.i_remainder(m_funct == rv_isa_pkg::REM || m_funct == rv_isa_pkg::REMU),
		.o_valid(stage_valid[0]),
		.o_dividend_mag(stage_rest[0]),
		.o_divisor_mag(stage_divisor[0]),
		.o_quotient_negative(stage_quotient_negative[0]),
		.o_remainder_negative(stage_remainder_negative[0]),
		.o_by_zero(stage_by_zero[0]),
		.o_overflow(stage_overflow[0]),
		.o_remainder_sel(stage_remainder_sel[0]),
		.o_raw_dividend(stage_raw_dividend[0])
	);

	assign stage_quotient[0] = '0;
	assign stage_remainder[0] = '0;

	for (genvar s = 0; s < `CPU_DIV_STAGES; s++) begin : g_div_stage
		cpu_divide_stage i_cpu_divide_stage (
			.i_clock(i_clock),
			.i_reset(i_reset),
			.i_valid(stage_valid[s]),
			.i_quotient(stage_quotient[s]),
			.i_partial_remainder(stage_remainder[s]),
			.i_dividend_rest(stage_rest[s]),
			.i_divisor(stage_divisor[s]),
			.i_quotient_negative(stage_quotient_negative[s]),
			.i_remainder_negative(stage_remainder_negative[s]),
			.i_by_zero(stage_by_zero[s]),
			.i_overflow(stage_overflow[s]),
			.i_remainder_sel(stage_remainder_sel[s]),
			.i_raw_dividend(stage_raw_dividend[s]),
			.o_valid(stage_valid[s+1]),
			.o_quotient(stage_quotient[s+1]),
			.o_partial_remainder(stage_remainder[s+1]),
			.o_dividend_rest(stage_rest[s+1]),
			.o_divisor(stage_divisor[s+1]),
			.o_quotient_negative(stage_quotient_negative[s+1]),
			.o_remainder_negative(stage_remainder_negative[s+1]),
			.o_by_zero(stage_by_zero[s+1]),
			.o_overflow(stage_overflow[s+1]),
			.o_remainder_sel(stage_remainder_sel[s+1]),
			.o_raw_dividend(stage_raw_dividend[s+1])
		);
	end

	cpu_divide_finish i_cpu_divide_finish (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_valid(stage_valid[`CPU_DIV_STAGES]),
		.i_quotient(stage_quotient[`CPU_DIV_STAGES]),
		.i_remainder(stage_remainder[`CPU_DIV_STAGES]),
		.i_quotient_negative(stage_quotient_negative[`CPU_DIV_STAGES]),
		.i_remainder_negative(stage_remainder_negative[`CPU_DIV_STAGES]),
		.i_by_zero(stage_by_zero[`CPU_DIV_STAGES]),
		.i_overflow(stage_overflow[`CPU_DIV_STAGES]),
		.i_remainder_sel(stage_remainder_sel[`CPU_DIV_STAGES]),
		.i_raw_dividend(stage_raw_dividend[`CPU_DIV_STAGES]),
		.o_done(div_done),
		.o_result(div_result)
	);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= cpu_types_pkg::IDLE;
			mul_primed <= 1'b0;
			o_tag <= '0;
			o_pc_next <= '0;
			o_mem_address <= '0;
			o_mem_read <= 1'b0;
			o_mem_write <= 1'b0;
		end else begin
			case (state)
				cpu_types_pkg::IDLE: begin
					if (accept) begin
						o_inst_rd <= i_inst_rd;
						o_pc_next <= pc_plus4;
						o_mem_read <= 1'b0;
						o_mem_write <= 1'b0;
						o_mem_width <= 3'd0;
						if (is_mul) begin
							mul_primed <= 1'b0;
							state <= cpu_types_pkg::MUL_WAIT;
						end else if (is_div) begin
							state <= cpu_types_pkg::DIV_WAIT;
						end else begin
							o_tag <= i_tag;
							case (opcode)
								rv_isa_pkg::OP, rv_isa_pkg::OP_IMM, rv_isa_pkg::AUIPC: begin
									o_rd <= alu_result;
								end
								rv_isa_pkg::LUI: o_rd <= i_imm;
								rv_isa_pkg::JAL: begin
									o_rd <= pc_plus4;
									o_pc_next <= pc_imm;
								end
								rv_isa_pkg::JALR: begin
									o_rd <= pc_plus4;
									o_pc_next <= {alu_result[31:1], 1'b0};
								end
								rv_isa_pkg::BRANCH: begin
									if (alu_result[0]) begin
										o_pc_next <= pc_imm;
									end
								end
								rv_isa_pkg::LOAD: begin
									o_mem_address <= alu_result;
									o_mem_read <= 1'b1;
									o_mem_width <= mem_width;
									o_mem_signed <= mem_signed;
								end
								rv_isa_pkg::STORE: begin
									o_mem_address <= alu_result;
									o_mem_write <= 1'b1;
									o_mem_width <= mem_width;
									o_mem_signed <= 1'b0;
									o_rd <= i_rs2;
								end
								// unknown opcodes retire as a no-op
								default: begin
								end
							endcase
						end
					end
				end
				cpu_types_pkg::MUL_WAIT: begin
					// the first edge loads the product register, the second takes its result
					if (mul_primed) begin
						o_rd <= mul_result;
						o_tag <= i_tag;
						state <= cpu_types_pkg::IDLE;
					end else begin
						mul_primed <= 1'b1;
					end
				end
				cpu_types_pkg::DIV_WAIT: begin
					if (div_done) begin
						o_rd <= div_result;
						o_tag <= i_tag;
						state <= cpu_types_pkg::IDLE;
					end
				end
				default: state <= cpu_types_pkg::IDLE;
			endcase
		end
	end

endmodule

// ==== sim/tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock (
	output logic o_clock
);

	// 4 ns period
	initial begin
		o_clock = 1'b0;
		forever begin
			#2 o_clock = ~o_clock;
		end
	end

endmodule

// ==== sim/cpu_execute_tb.sv ====
`timescale 1ns/100ps

module cpu_execute_tb;

	localparam int ALU_COUNT = 60;
	localparam int CONTROL_COUNT = 40;
	localparam int MEMORY_COUNT = 30;
	localparam int MUL_COUNT = 30;
	localparam int DIV_COUNT = 40;
	localparam int HOLD_COUNT = 20;
	// every memory instruction is followed by an ALU instruction
	localparam int INSTR_COUNT = ALU_COUNT + CONTROL_COUNT + 2 * MEMORY_COUNT + MUL_COUNT
		+ DIV_COUNT + HOLD_COUNT;
	localparam int TIMEOUT_NS = (INSTR_COUNT + 1) * 16 * 4;

	logic clock;
	logic reset;
	logic stall;
	cpu_types_pkg::tag_t tag;
	cpu_types_pkg::word_t pc;
	cpu_types_pkg::word_t instruction;
	cpu_types_pkg::word_t rs1;
	cpu_types_pkg::word_t rs2;
	cpu_types_pkg::word_t imm;
	cpu_types_pkg::reg_index_t inst_rd;
	cpu_types_pkg::tag_t done_tag;
	cpu_types_pkg::reg_index_t done_inst_rd;
	cpu_types_pkg::word_t rd;
	cpu_types_pkg::word_t pc_next;
	cpu_types_pkg::word_t mem_address;
	logic mem_read;
	logic mem_write;
	logic mem_signed;
	cpu_types_pkg::mem_width_t mem_width;
	logic busy;
	cpu_types_pkg::tag_t next_tag;

	tb_clock i_tb_clock (
		.o_clock(clock)
	);

	cpu_execute i_cpu_execute (
		.i_clock(clock),
		.i_reset(reset),
		.i_stall(stall),
		.i_tag(tag),
		.i_pc(pc),
		.i_instruction(instruction),
		.i_rs1(rs1),
		.i_rs2(rs2),
		.i_imm(imm),
		.i_inst_rd(inst_rd),
		.o_tag(done_tag),
		.o_inst_rd(done_inst_rd),
		.o_rd(rd),
		.o_pc_next(pc_next),
		.o_mem_address(mem_address),
		.o_mem_read(mem_read),
		.o_mem_write(mem_write),
		.o_mem_signed(mem_signed),
		.o_mem_width(mem_width),
		.o_stall(busy)
	);

	task automatic stop_run(input string reason);
		$display("%s", reason);
		$display("Test failures found");
		$fatal(1, "stopping at the first failure");
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			stop_run($sformatf("Fail %s: got %h, expected %h", name, actual, expected));
		end
	endtask

	function automatic cpu_types_pkg::word_t alu_model(input logic [2:0] f3, input logic alt,
		input cpu_types_pkg::word_t a, input cpu_types_pkg::word_t b);
		case (f3)
			3'b000: return alt ? a - b : a + b;
			3'b001: return a << b[4:0];
			3'b010: return cpu_types_pkg::word_t'($signed(a) < $signed(b));
			3'b011: return cpu_types_pkg::word_t'(a < b);
			3'b100: return a ^ b;
			3'b101: return alt ? cpu_types_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_taken(input logic [2:0] f3, input cpu_types_pkg::word_t a,
		input cpu_types_pkg::word_t b);
		case (f3)
			3'b000: return a == b;
			3'b001: return a != b;
			3'b100: return $signed(a) < $signed(b);
			3'b101: return $signed(a) >= $signed(b);
			3'b110: return a < b;
			default: return a >= b;
		endcase
	endfunction

	// the low 64 bits of the extended product hold the full signed or unsigned result
	function automatic cpu_types_pkg::word_t multiply_model(input logic [2:0] f3,
		input cpu_types_pkg::word_t a, input cpu_types_pkg::word_t b);
		logic [63:0] a_ext;
		logic [63:0] b_ext;
		logic [63:0] product;
		a_ext = {{32{a[31] && (f3 == 3'b001 || f3 == 3'b010)}}, a};
		b_ext = {{32{b[31] && f3 == 3'b001}}, b};
		product = a_ext * b_ext;
		return f3 == 3'b000 ? product[31:0] : product[63:32];
	endfunction

	function automatic cpu_types_pkg::word_t divide_model(input logic [2:0] f3,
		input cpu_types_pkg::word_t a, input cpu_types_pkg::word_t b);
		logic is_signed;
		logic is_rem;
		is_signed = !f3[0];
		is_rem = f3[1];
		if (b == 32'd0) begin
			return is_rem ? a : 32'hffff_ffff;
		end
		if (is_signed && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
			return is_rem ? 32'd0 : a;
		end
		if (is_signed) begin
			return is_rem ? cpu_types_pkg::word_t'($signed(a) % $signed(b))
				: cpu_types_pkg::word_t'($signed(a) / $signed(b));
		end
		return is_rem ? a % b : a / b;
	endfunction

	function automatic cpu_types_pkg::word_t random_imm12();
		cpu_types_pkg::word_t raw;
		raw = $urandom;
		return {{20{raw[11]}}, raw[11:0]};
	endfunction

	// rs1 is x1 and rs2 is x2, the DUT takes the operand values from the ports
	function automatic cpu_types_pkg::word_t encode(input logic [6:0] opcode,
		input logic [2:0] f3, input logic [11:0] upper);
		return {upper, 5'd1, f3, inst_rd, opcode};
	endfunction

	task automatic randomize_operands();
		pc = $urandom & 32'hffff_fffc;
		rs1 = $urandom;
		rs2 = $urandom;
		imm = random_imm12();
		inst_rd = 5'($urandom);
	endtask

	task automatic hold_outputs(input int cycles);
		cpu_types_pkg::tag_t tag_before;
		cpu_types_pkg::reg_index_t inst_rd_before;
		cpu_types_pkg::word_t rd_before;
		cpu_types_pkg::word_t pc_next_before;
		cpu_types_pkg::word_t address_before;
		cpu_types_pkg::mem_width_t width_before;
		logic signed_before;
		logic [2:0] flags_before;
		tag_before = done_tag;
		inst_rd_before = done_inst_rd;
		rd_before = rd;
		pc_next_before = pc_next;
		address_before = mem_address;
		width_before = mem_width;
		signed_before = mem_signed;
		flags_before = {mem_read, mem_write, busy};
		repeat (cycles) begin
			@(negedge clock);
			check_value("o_tag", 32'(done_tag), 32'(tag_before));
			check_value("o_inst_rd", 32'(done_inst_rd), 32'(inst_rd_before));
			check_value("o_rd", rd, rd_before);
			check_value("o_pc_next", pc_next, pc_next_before);
			check_value("o_mem_address", mem_address, address_before);
			check_value("o_mem_width", 32'(mem_width), 32'(width_before));
			check_value("o_mem_signed", 32'(mem_signed), 32'(signed_before));
			check_value("o_mem_read/o_mem_write/o_stall", 32'({mem_read, mem_write, busy}),
				32'(flags_before));
		end
	endtask

	// hold keeps i_stall high for that many cycles before the instruction may start
	task automatic execute(input cpu_types_pkg::word_t instr, input int latency, input int hold);
		int cycles;
		next_tag = next_tag + 8'd1;
		tag = next_tag;
		instruction = instr;
		stall = hold > 0;
		hold_outputs(hold);
		stall = 1'b0;
		cycles = 0;
		do begin
			@(negedge clock);
			cycles++;
			if (done_tag !== tag) begin
				check_value("o_stall", 32'(busy), 32'(latency > 1));
				if (cycles > 32) begin
					stop_run($sformatf("instruction with tag %h did not finish in 32 cycles", tag));
				end
			end
		end while (done_tag !== tag);
		check_value("latency in cycles", cycles, latency);
		check_value("o_inst_rd", 32'(done_inst_rd), 32'(inst_rd));
		check_value("o_stall", 32'(busy), 32'd0);
	endtask

	task automatic test_alu(input int hold);
		logic [2:0] f3;
		logic alt;
		cpu_types_pkg::word_t expected;
		int kind;
		randomize_operands();
		kind = $urandom_range(3, 0);
		f3 = 3'($urandom);
		// SUB and SRA exist in the register form, only SRAI in the immediate form
		alt = 1'($urandom) && (f3 == 3'b101 || (kind == 0 && f3 == 3'b000));
		if (kind == 0) begin
			expected = alu_model(f3, alt, rs1, rs2);
			execute(encode(rv_isa_pkg::OP, f3, {1'b0, alt, 10'd2}), 1, hold);
		end else if (kind == 1) begin
			if (f3[1:0] == 2'b01) begin
				imm = {20'd0, 1'b0, alt, 5'd0, 5'($urandom)};
			end
			expected = alu_model(f3, alt, rs1, imm);
			execute(encode(rv_isa_pkg::OP_IMM, f3, imm[11:0]), 1, hold);
		end else begin
			imm = $urandom & 32'hffff_f000;
			expected = kind == 2 ? imm : pc + imm;
			execute(encode(kind == 2 ? rv_isa_pkg::LUI : rv_isa_pkg::AUIPC, f3, imm[31:20]),
				1, hold);
		end
		check_value("o_rd", rd, expected);
		check_value("o_pc_next", pc_next, pc + 32'd4);
		check_value("o_mem_read", 32'(mem_read), 32'd0);
		check_value("o_mem_write", 32'(mem_write), 32'd0);
	endtask

	task automatic test_control();
		logic [2:0] f3;
		cpu_types_pkg::word_t link;
		cpu_types_pkg::word_t target;
		int kind;
		randomize_operands();
		kind = $urandom_range(2, 0);
		link = pc + 32'd4;
		if (kind == 0) begin
			f3 = 3'($urandom_range(5, 0));
			if (f3 > 3'd1) begin
				f3 = f3 + 3'd2;
			end
			if ($urandom_range(3, 0) == 0) begin
				rs2 = rs1;
			end
			target = branch_taken(f3, rs1, rs2) ? pc + imm : link;
			execute(encode(rv_isa_pkg::BRANCH, f3, 12'($urandom)), 1, 0);
			check_value("o_pc_next", pc_next, target);
		end else if (kind == 1) begin
			imm = random_imm12() << 1;
			execute(encode(rv_isa_pkg::JAL, 3'd0, 12'($urandom)), 1, 0);
			check_value("o_pc_next", pc_next, pc + imm);
			check_value("o_rd", rd, link);
		end else begin
			target = (rs1 + imm) & 32'hffff_fffe;
			execute(encode(rv_isa_pkg::JALR, 3'd0, imm[11:0]), 1, 0);
			check_value("o_pc_next", pc_next, target);
			check_value("o_rd", rd, link);
		end
	endtask

	task automatic test_memory();
		logic [2:0] f3;
		logic [2:0] width;
		logic is_store;
		randomize_operands();
		is_store = 1'($urandom);
		if (is_store) begin
			f3 = 3'($urandom_range(2, 0));
		end else begin
			f3 = 3'($urandom_range(4, 0));
			if (f3 == 3'd3 || f3 == 3'd4) begin
				f3 = f3 + 3'd1;
			end
		end
		width = 3'd1 << f3[1:0];
		execute(encode(is_store ? rv_isa_pkg::STORE : rv_isa_pkg::LOAD, f3, 12'($urandom)), 1, 0);
		check_value("o_mem_address", mem_address, rs1 + imm);
		check_value("o_mem_width", 32'(mem_width), 32'(width));
		// a word load needs no extension and is reported as unsigned
		check_value("o_mem_signed", 32'(mem_signed), 32'(!is_store && !f3[2] && f3[1:0] != 2'b10));
		check_value("o_mem_read", 32'(mem_read), 32'(!is_store));
		check_value("o_mem_write", 32'(mem_write), 32'(is_store));
		check_value("o_pc_next", pc_next, pc + 32'd4);
		if (is_store) begin
			check_value("o_rd", rd, rs2);
		end
	endtask

	task automatic test_multiply();
		logic [2:0] f3;
		randomize_operands();
		f3 = 3'($urandom_range(3, 0));
		execute(encode(rv_isa_pkg::OP, f3, 12'b0000001_00010), 3, 0);
		check_value("o_rd", rd, multiply_model(f3, rs1, rs2));
	endtask

	task automatic test_divide();
		logic [2:0] f3;
		int kind;
		randomize_operands();
		f3 = {1'b1, 2'($urandom)};
		kind = $urandom_range(7, 0);
		if (kind == 0) begin
			rs2 = 32'd0;
		end else if (kind == 1) begin
			rs1 = 32'h8000_0000;
			rs2 = 32'hffff_ffff;
		end else if (kind < 5) begin
			// small divisors give quotients with many significant bits
			rs2 = rs2 >> $urandom_range(28, 12);
			if (kind == 4) begin
				rs2 = -rs2;
			end
		end
		execute(encode(rv_isa_pkg::OP, f3, 12'b0000001_00010), 11, 0);
		check_value("o_rd", rd, divide_model(f3, rs1, rs2));
	endtask

	task automatic test_hold();
		randomize_operands();
		instruction = $urandom;
		// the tag still equals the last finished one, so nothing may start
		hold_outputs($urandom_range(6, 1));
		test_alu($urandom_range(6, 1));
	endtask

	initial begin
		#(TIMEOUT_NS);
		stop_run($sformatf("Timeout: the run did not finish within %0d ns", TIMEOUT_NS));
	end

	initial begin
		void'($urandom(32'hee35));
		reset = 1'b1;
		stall = 1'b0;
		tag = '0;
		pc = '0;
		instruction = '0;
		rs1 = '0;
		rs2 = '0;
		imm = '0;
		inst_rd = '0;
		next_tag = '0;
		repeat (16) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		check_value("o_tag", 32'(done_tag), 32'd0);
		check_value("o_pc_next", pc_next, 32'd0);
		check_value("o_mem_address", mem_address, 32'd0);
		check_value("o_mem_read", 32'(mem_read), 32'd0);
		check_value("o_mem_write", 32'(mem_write), 32'd0);
		check_value("o_stall", 32'(busy), 32'd0);
		repeat (ALU_COUNT) test_alu(0);
		repeat (CONTROL_COUNT) test_control();
		repeat (MEMORY_COUNT) begin
			test_memory();
			test_alu(0);
		end
		repeat (MUL_COUNT) test_multiply();
		repeat (DIV_COUNT) test_divide();
		repeat (HOLD_COUNT) test_hold();
		$display("All tests passed!");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+src
src/cpu_types_pkg.sv
src/rv_isa_pkg.sv
src/cpu_alu.sv
src/cpu_multiply.sv
src/cpu_divide_prepare.sv
src/cpu_divide_stage.sv
src/cpu_divide_finish.sv
src/cpu_execute.sv
sim/tb_clock.sv
sim/cpu_execute_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module cpu_execute_tb -o cpu_execute_sim

# the exit status of the simulation is not used, the log decides
./obj_dir/cpu_execute_sim | tee sim.log

if grep -q "Test failures found" sim.log; then
	echo "simulation failed"
	exit 1
fi

if ! grep -q "All tests passed!" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi

echo "simulation passed"
